//--- hw/plru_pkg.sv
/*
 * Shared definitions for the 8-way pseudo-LRU replacement block.
 * Holds the cache geometry, the request kind encoding and the request
 * payload union. Import with a wildcard in each module header.
 */

`default_nettype none

package plru_pkg;

    // Cache geometry
    localparam int NUM_WAYS = 8;
    localparam int NUM_SETS = 64;
    localparam int INDEX_W  = $clog2(NUM_SETS);

    // One bit per internal tree node, heap order with node 0 as the root
    localparam int NODE_W = NUM_WAYS - 1;

    // Request kind
    localparam logic OP_HIT   = 1'b0;
    localparam logic OP_EVICT = 1'b1;

    // Request payload, decoded by the request kind that travels with it.
    // A hit carries the one-hot way that hit.
    // An evict carries the scratchpad lock mask, a set bit forbids that way.
    typedef union packed {
        logic [NUM_WAYS-1:0] hit_way;
        logic [NUM_WAYS-1:0] lock_mask;
    } req_payload_u;

endpackage

`default_nettype wire

//--- hw/plru_state_ram.sv
/*
 * Per-set PLRU state array built from flops.
 * One synchronous read port and one write port; a read of the index being
 * written in the same cycle returns the new word.
 */

`timescale 1ns/100ps
`default_nettype none

module plru_state_ram import plru_pkg::*; (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire logic [INDEX_W-1:0] rd_index_i,
    output logic      [NODE_W-1:0]  rd_state_o,
    input  wire logic               wr_en_i,
    input  wire logic [INDEX_W-1:0] wr_index_i,
    input  wire logic [NODE_W-1:0]  wr_state_i
);

    logic [NODE_W-1:0] state_q [NUM_SETS];
    logic [NODE_W-1:0] rd_state_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                state_q[s] <= '0;
            end
            rd_state_q <= '0;
        end else begin
            if (wr_en_i) begin
                state_q[wr_index_i] <= wr_state_i;
            end
            // Write-first bypass so back-to-back requests to one set chain
            if (wr_en_i && (wr_index_i == rd_index_i)) begin
                rd_state_q <= wr_state_i;
            end else begin
                rd_state_q <= state_q[rd_index_i];
            end
        end
    end

    assign rd_state_o = rd_state_q;

endmodule

`default_nettype wire

//--- hw/plru_request_stage.sv
/*
 * First pipeline stage of the replacement block.
 * Accepts a request, issues the state read in the same cycle and holds
 * the request while the state word is fetched or the output is stalled.
 */

`timescale 1ns/100ps
`default_nettype none

module plru_request_stage import plru_pkg::*; (
    input  wire logic                clk_i,
    input  wire logic                reset_i,
    // Upstream request
    input  wire logic                in_valid_i,
    output logic                     in_ready_o,
    input  wire logic                in_op_i,
    input  wire logic [INDEX_W-1:0]  in_index_i,
    input  wire req_payload_u        in_payload_i,
    input  wire logic [NUM_WAYS-1:0] in_dirty_i,
    // Held item towards the tree stage
    input  wire logic                advance_i,
    output logic                     s1_valid_o,
    output logic                     s1_op_o,
    output logic      [INDEX_W-1:0]  s1_index_o,
    output req_payload_u             s1_payload_o,
    output logic      [NUM_WAYS-1:0] s1_dirty_o,
    // State array read address
    output logic      [INDEX_W-1:0]  rd_index_o
);

    logic                s1_valid_q;
    logic                s1_op_q;
    logic [INDEX_W-1:0]  s1_index_q;
    req_payload_u        s1_payload_q;
    logic [NUM_WAYS-1:0] s1_dirty_q;
    logic                accept;

    // Free when empty or when the held item moves on this edge
    assign in_ready_o = !s1_valid_q || advance_i;
    assign accept     = in_valid_i && in_ready_o;

    // Read goes out with acceptance, otherwise keep re-reading the held set
    assign rd_index_o = in_ready_o ? in_index_i : s1_index_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_valid_q <= 1'b0;
        end else if (accept) begin
            s1_valid_q <= 1'b1;
        end else if (advance_i) begin
            s1_valid_q <= 1'b0;
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (accept) begin
            s1_op_q      <= in_op_i;
            s1_index_q   <= in_index_i;
            s1_payload_q <= in_payload_i;
            s1_dirty_q   <= in_dirty_i;
        end
    end

    assign s1_valid_o   = s1_valid_q;
    assign s1_op_o      = s1_op_q;
    assign s1_index_o   = s1_index_q;
    assign s1_payload_o = s1_payload_q;
    assign s1_dirty_o   = s1_dirty_q;

endmodule

`default_nettype wire

//--- hw/plru_tree_update.sv
/*
 * Second pipeline stage of the replacement block.
 * Walks the PLRU tree for an evict victim, marks the accessed way as
 * recently used, writes the new word back and registers the response.
 */

`timescale 1ns/100ps
`default_nettype none

module plru_tree_update import plru_pkg::*; (
    input  wire logic                clk_i,
    input  wire logic                reset_i,
    // Item held in stage 1
    input  wire logic                s1_valid_i,
    input  wire logic                s1_op_i,
    input  wire logic [INDEX_W-1:0]  s1_index_i,
    input  wire req_payload_u        s1_payload_i,
    input  wire logic [NUM_WAYS-1:0] s1_dirty_i,
    input  wire logic [NODE_W-1:0]   rd_state_i,
    output logic                     advance_o,
    // State write-back
    output logic                     wr_en_o,
    output logic      [INDEX_W-1:0]  wr_index_o,
    output logic      [NODE_W-1:0]   wr_state_o,
    // Response
    output logic                     out_valid_o,
    input  wire logic                out_ready_i,
    output logic                     out_op_o,
    output logic      [NUM_WAYS-1:0] out_way_o,
    output logic                     out_writeback_o
);

    // Node n steers to child 2n+1 (lower way numbers) when 0, to 2n+2 when 1.
    // Skips a half whose ways are all locked.
    function automatic int pick_victim(logic [NODE_W-1:0] state, logic [NUM_WAYS-1:0] lock);
        int   node;
        int   base;
        int   half;
        logic low_free;
        logic high_free;
        logic take_high;
        node = 0;
        base = 0;
        for (int size = NUM_WAYS; size > 1; size = size / 2) begin
            half      = size / 2;
            low_free  = 1'b0;
            high_free = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (w >= base && w < base + half) begin
                    low_free = low_free | !lock[w];
                end
                if (w >= base + half && w < base + size) begin
                    high_free = high_free | !lock[w];
                end
            end
            take_high = state[node] ? high_free : !low_free;
            if (take_high) begin
                base = base + half;
                node = 2 * node + 2;
            end else begin
                node = 2 * node + 1;
            end
        end
        return base;
    endfunction

    // Point every node on the path away from the accessed way
    function automatic logic [NODE_W-1:0] touch_way(logic [NODE_W-1:0] state, int way);
        logic [NODE_W-1:0] new_state;
        int                node;
        int                base;
        int                half;
        new_state = state;
        node      = 0;
        base      = 0;
        for (int size = NUM_WAYS; size > 1; size = size / 2) begin
            half = size / 2;
            if (way < base + half) begin
                new_state[node] = 1'b1;
                node            = 2 * node + 1;
            end else begin
                new_state[node] = 1'b0;
                base            = base + half;
                node            = 2 * node + 2;
            end
        end
        return new_state;
    endfunction

    function automatic int way_index(logic [NUM_WAYS-1:0] onehot);
        int idx;
        idx = 0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (onehot[w]) begin
                idx = w;
            end
        end
        return idx;
    endfunction

    int                  access_way;
    logic [NUM_WAYS-1:0] victim_oh;
    logic                writeback;
    logic                out_valid_q;
    logic                out_op_q;
    logic [NUM_WAYS-1:0] out_way_q;
    logic                out_writeback_q;

    always_comb begin
        if (s1_op_i == OP_EVICT) begin
            access_way = pick_victim(rd_state_i, s1_payload_i.lock_mask);
            victim_oh  = NUM_WAYS'(1) << access_way;
        end else begin
            access_way = way_index(s1_payload_i.hit_way);
            victim_oh  = '0;
        end
        writeback = |(s1_dirty_i & victim_oh);
    end

    // Move on when the response register is free or being drained
    assign advance_o  = s1_valid_i && (!out_valid_q || out_ready_i);
    assign wr_en_o    = advance_o;
    assign wr_index_o = s1_index_i;
    assign wr_state_o = touch_way(rd_state_i, access_way);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
        end else if (advance_o) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // Response payload only loads when a new item moves in
    always_ff @(posedge clk_i) begin
        if (advance_o) begin
            out_op_q        <= s1_op_i;
            out_way_q       <= victim_oh;
            out_writeback_q <= writeback;
        end
    end

    assign out_valid_o     = out_valid_q;
    assign out_op_o        = out_op_q;
    assign out_way_o       = out_way_q;
    assign out_writeback_o = out_writeback_q;

endmodule

`default_nettype wire

//--- hw/plru_replacement.sv
/*
 * Top level of the 8-way pseudo-LRU replacement block.
 * Connects the request stage, the state array and the tree update stage.
 * Requests and responses use valid/ready handshakes.
 */

`timescale 1ns/100ps
`default_nettype none

module plru_replacement import plru_pkg::*; (
    input  wire logic                clk_i,
    input  wire logic                reset_i,
    // Request side
    input  wire logic                in_valid_i,
    output logic                     in_ready_o,
    input  wire logic                in_op_i,
    input  wire logic [INDEX_W-1:0]  in_index_i,
    input  wire req_payload_u        in_payload_i,
    input  wire logic [NUM_WAYS-1:0] in_dirty_i,
    // Response side
    output logic                     out_valid_o,
    input  wire logic                out_ready_i,
    output logic                     out_op_o,
    output logic      [NUM_WAYS-1:0] out_way_o,
    output logic                     out_writeback_o
);

    logic                s1_valid;
    logic                s1_op;
    logic [INDEX_W-1:0]  s1_index;
    req_payload_u        s1_payload;
    logic [NUM_WAYS-1:0] s1_dirty;
    logic                advance;
    logic [INDEX_W-1:0]  rd_index;
    logic [NODE_W-1:0]   rd_state;
    logic                wr_en;
    logic [INDEX_W-1:0]  wr_index;
    logic [NODE_W-1:0]   wr_state;

    plru_request_stage u_request_stage (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_op_i      (in_op_i),
        .in_index_i   (in_index_i),
        .in_payload_i (in_payload_i),
        .in_dirty_i   (in_dirty_i),
        .advance_i    (advance),
        .s1_valid_o   (s1_valid),
        .s1_op_o      (s1_op),
        .s1_index_o   (s1_index),
        .s1_payload_o (s1_payload),
        .s1_dirty_o   (s1_dirty),
        .rd_index_o   (rd_index)
    );

    plru_state_ram u_state_ram (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rd_index_i (rd_index),
        .rd_state_o (rd_state),
        .wr_en_i    (wr_en),
        .wr_index_i (wr_index),
        .wr_state_i (wr_state)
    );

    plru_tree_update u_tree_update (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .s1_valid_i      (s1_valid),
        .s1_op_i         (s1_op),
        .s1_index_i      (s1_index),
        .s1_payload_i    (s1_payload),
        .s1_dirty_i      (s1_dirty),
        .rd_state_i      (rd_state),
        .advance_o       (advance),
        .wr_en_o         (wr_en),
        .wr_index_o      (wr_index),
        .wr_state_o      (wr_state),
        .out_valid_o     (out_valid_o),
        .out_ready_i     (out_ready_i),
        .out_op_o        (out_op_o),
        .out_way_o       (out_way_o),
        .out_writeback_o (out_writeback_o)
    );

endmodule

`default_nettype wire

//--- verif/plru_assertions.sv
/*
 * Concurrent checks on the replacement block's ports, bound to the top level.
 * Covers response stability under stall, evict legality and victim encoding.
 */

`timescale 1ns/100ps
`default_nettype none

module plru_assertions import plru_pkg::*; (
    input wire logic                clk_i,
    input wire logic                reset_i,
    input wire logic                in_valid_i,
    input wire logic                in_op_i,
    input wire req_payload_u        in_payload_i,
    input wire logic                out_valid_o,
    input wire logic                out_ready_i,
    input wire logic                out_op_o,
    input wire logic [NUM_WAYS-1:0] out_way_o,
    input wire logic                out_writeback_o
);

    // A stalled response keeps valid and payload until it transfers
    stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_op_o)
            && $stable(out_way_o) && $stable(out_writeback_o))
        else $error("Response changed while the output was stalled");

    // At least one way has to stay free for an evict
    evict_has_free_way: assert property (@(posedge clk_i) disable iff (reset_i)
        in_valid_i && (in_op_i == OP_EVICT) |-> !(&in_payload_i.lock_mask))
        else $error("Evict request arrived with every way locked");

    victim_encoding: assert property (@(posedge clk_i) disable iff (reset_i)
        out_valid_o |-> ((out_op_o == OP_EVICT) ? $onehot(out_way_o) : (out_way_o == '0)))
        else $error("Response way is not one-hot on an evict or not zero on a hit");

endmodule

bind plru_replacement plru_assertions u_plru_assertions (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .in_valid_i      (in_valid_i),
    .in_op_i         (in_op_i),
    .in_payload_i    (in_payload_i),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .out_op_o        (out_op_o),
    .out_way_o       (out_way_o),
    .out_writeback_o (out_writeback_o)
);

`default_nettype wire

//--- verif/tb_plru_replacement.sv
/*
 * Testbench for the 8-way pseudo-LRU replacement block.
 * Sends directed and random requests, predicts every response with a
 * reference model of the PLRU tree and compares each transfer in order.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_plru_replacement import plru_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        logic                op;
        logic [NUM_WAYS-1:0] way;
        logic                writeback;
        logic [NUM_WAYS-1:0] lock;
    } expect_t;

    logic                clk_i;
    logic                reset_i;
    logic                in_valid_i;
    logic                in_ready_o;
    logic                in_op_i;
    logic [INDEX_W-1:0]  in_index_i;
    req_payload_u        in_payload_i;
    logic [NUM_WAYS-1:0] in_dirty_i;
    logic                out_valid_o;
    logic                out_ready_i;
    logic                out_op_o;
    logic [NUM_WAYS-1:0] out_way_o;
    logic                out_writeback_o;

    integer              seed;
    logic                ready_random;
    logic [NODE_W-1:0]   model_state [NUM_SETS];
    expect_t             exp_q [$];
    logic                exp_valid;
    logic                s1_pending;
    logic [NUM_WAYS-1:0] last_way;
    logic [NUM_WAYS-1:0] seen_ways;

    plru_replacement u_plru_replacement (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, expected);
            abort_run();
        end
    endtask

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic logic [NUM_WAYS-1:0] legal_lock(logic [31:0] rnd);
        logic [NUM_WAYS-1:0] lock;
        lock = rnd[15:8] | rnd[23:16];
        // Keep one way free
        if (&lock) begin
            lock[rnd[2:0]] = 1'b0;
        end
        return lock;
    endfunction

    // Reference model of the three-level tree in heap order where bit 1 steers to higher ways
    function automatic expect_t predict(logic op, logic [INDEX_W-1:0] idx,
                                        req_payload_u payload, logic [NUM_WAYS-1:0] dirty);
        expect_t           e;
        logic [NODE_W-1:0] st;
        logic [2:0]        way;
        logic              lo_free;
        logic              hi_free;
        int                node;
        st  = model_state[idx];
        way = 3'd0;
        if (op == OP_EVICT) begin
            // Settle the way number one bit per level from the root down
            for (int b = 2; b >= 0; b--) begin
                node    = (1 << (2 - b)) - 1 + int'(way >> (b + 1));
                lo_free = 1'b0;
                hi_free = 1'b0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    if ((w >> (b + 1)) == int'(way >> (b + 1)) && !payload.lock_mask[w]) begin
                        if (w[b]) begin
                            hi_free = 1'b1;
                        end else begin
                            lo_free = 1'b1;
                        end
                    end
                end
                way[b] = (st[node] && hi_free) || (!st[node] && !lo_free);
            end
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (payload.hit_way[w]) begin
                    way = 3'(w);
                end
            end
        end
        // Every node on the path now points away from the accessed way
        for (int b = 2; b >= 0; b--) begin
            node     = (1 << (2 - b)) - 1 + int'(way >> (b + 1));
            st[node] = !way[b];
        end
        model_state[idx] = st;
        e.op        = op;
        e.way       = (op == OP_EVICT) ? NUM_WAYS'(1) << way : '0;
        e.writeback = (op == OP_EVICT) && dirty[way];
        e.lock      = payload.lock_mask;
        return e;
    endfunction

    // Starts just after a rising edge and returns just after the accepting edge
    task automatic send_request(logic op, logic [INDEX_W-1:0] idx,
                                logic [NUM_WAYS-1:0] payload, logic [NUM_WAYS-1:0] dirty);
        int cycles;
        in_valid_i   = 1'b1;
        in_op_i      = op;
        in_index_i   = idx;
        in_payload_i = req_payload_u'(payload);
        in_dirty_i   = dirty;
        cycles       = 0;
        @(negedge clk_i);
        while (!in_ready_o) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Request was not accepted before the timeout");
                abort_run();
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic wait_drained();
        int cycles;
        in_valid_i = 1'b0;
        cycles     = 0;
        while (exp_q.size() != 0) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Outstanding responses did not arrive before the timeout");
                abort_run();
            end
            @(posedge clk_i);
            #1;
        end
    endtask

    // Consumer drives a little later than the producer
    initial begin
        logic [31:0] rnd;
        out_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            #2;
            rnd         = next_random();
            out_ready_i = ready_random ? rnd[0] : 1'b1;
        end
    end

    // Compare process sampling at the falling edge where all signals are settled
    initial begin
        expect_t e;
        logic    free;
        logic    accept;
        exp_valid  = 1'b0;
        s1_pending = 1'b0;
        forever begin
            @(negedge clk_i);
            free   = !out_valid_o || out_ready_i;
            accept = in_valid_i && in_ready_o;
            if (reset_i) begin
                exp_valid  = 1'b0;
                s1_pending = 1'b0;
                exp_q.delete();
                for (int s = 0; s < NUM_SETS; s++) begin
                    model_state[s] = '0;
                end
            end else begin
                check("out_valid_o", 32'(out_valid_o), 32'(exp_valid));
                check("in_ready_o", 32'(in_ready_o), 32'(!s1_pending || free));
                if (out_valid_o && out_ready_i) begin
                    if (exp_q.size() == 0) begin
                        $display("Response transferred with no request outstanding");
                        abort_run();
                    end
                    e = exp_q.pop_front();
                    check("out_op_o", 32'(out_op_o), 32'(e.op));
                    check("out_way_o", 32'(out_way_o), 32'(e.way));
                    check("out_writeback_o", 32'(out_writeback_o), 32'(e.writeback));
                    if (e.op == OP_EVICT) begin
                        check("out_way_o & lock_mask", 32'(out_way_o & e.lock), 32'h0);
                    end
                    last_way  = out_way_o;
                    seen_ways = seen_ways | out_way_o;
                end
                if (accept) begin
                    exp_q.push_back(predict(in_op_i, in_index_i, in_payload_i, in_dirty_i));
                end
                // A held item loads the output register on the next free edge
                exp_valid  = free ? s1_pending : 1'b1;
                s1_pending = accept || (s1_pending && !free);
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] aux;
        seed         = 32'h86d494ad;
        ready_random = 1'b0;
        reset_i      = 1'b1;
        in_valid_i   = 1'b0;
        in_op_i      = OP_HIT;
        in_index_i   = '0;
        in_payload_i = '0;
        in_dirty_i   = '0;
        last_way     = '0;
        seen_ways    = '0;
        repeat (5) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        // Eight unlocked evicts on a fresh set visit every way once
        send_request(OP_EVICT, 6'd5, 8'h00, 8'h5a);
        wait_drained();
        check("first victim", 32'(last_way), 32'h01);
        repeat (7) begin
            send_request(OP_EVICT, 6'd5, 8'h00, 8'h5a);
        end
        wait_drained();
        check("ways covered", 32'(seen_ways), 32'hff);

        // A hit turns the root away from its own half
        for (int w = 0; w < NUM_WAYS; w++) begin
            send_request(OP_HIT, 6'(10 + w), NUM_WAYS'(1) << w, 8'hff);
            send_request(OP_EVICT, 6'(10 + w), 8'h00, 8'hff);
            wait_drained();
            check("victim half", 32'(w < 4 ? |last_way[7:4] : |last_way[3:0]), 32'h1);
        end

        // Upper half locked while the root points there and then random locks
        send_request(OP_HIT, 6'd30, 8'h01, 8'h00);
        repeat (4) begin
            send_request(OP_EVICT, 6'd30, 8'hf0, 8'h3c);
        end
        for (int i = 0; i < 32; i++) begin
            rnd = next_random();
            send_request(OP_EVICT, 6'd31, legal_lock(rnd), rnd[31:24]);
        end
        wait_drained();

        // Back-to-back traffic mostly to one set with a stalling consumer
        ready_random = 1'b1;
        for (int i = 0; i < 400; i++) begin
            rnd = next_random();
            aux = next_random();
            if (rnd[4]) begin
                send_request(OP_HIT, aux[16] ? 6'd40 : aux[5:0],
                             NUM_WAYS'(1) << rnd[2:0], aux[15:8]);
            end else begin
                send_request(OP_EVICT, aux[16] ? 6'd40 : aux[5:0],
                             legal_lock(rnd), aux[15:8]);
            end
        end
        wait_drained();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/plru_pkg.sv
hw/plru_state_ram.sv
hw/plru_request_stage.sv
hw/plru_tree_update.sv
hw/plru_replacement.sv
verif/plru_assertions.sv
verif/tb_plru_replacement.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the simulation's.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f filelist.f --top-module tb_plru_replacement \
    --Mdir obj_dir -o Vtb_plru_replacement &&
./obj_dir/Vtb_plru_replacement || { echo "Simulation failed"; exit 1; }
